// File: all.f
+incdir+common
+incdir+dv
common/cpuCtrlPkg.sv
src/instrDecoder.sv
src/ctrlSequencer.sv
src/controlTable.sv
src/cpuControl.sv
dv/cpuControlTb.sv

// File: Bender.yml
package:
  name: cpu_control

export_include_dirs:
  - common

sources:
  - files:
      - common/cpuCtrlPkg.sv
      - src/instrDecoder.sv
      - src/ctrlSequencer.sv
      - src/controlTable.sv
      - src/cpuControl.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/cpuControlTb.sv

// File: dv/ctrlRefModel.svh
// reference model of the control unit
// next state and expected control word per cycle, plus the stimulus LFSR

logic [16:0] lfsrState = 17'd67261;

// Fibonacci LFSR x^17 + x^14 + 1, stepped once per bit taken
function automatic logic [7:0] lfsrBits(input int width);
	logic [7:0] value;
	value = '0;
	for (int i = 0; i < width; i++)
	begin
		lfsrState = {lfsrState[15:0], lfsrState[16] ^ lfsrState[13]};
		value = {value[6:0], lfsrState[0]};
	end
	return value;
endfunction

// state sequence of each instruction class
function automatic ctrlState_t refNext(input ctrlState_t s, input opcode_t op);
	case (s)
		stReset:   return stFetch;
		stFetch:   return stDecode;
		stDecode:
			case (op)
				opAdd, opSub, opNand: return stAluExec;
				opShift:              return stShiftExec;
				opOri:                return stOriRead;
				opLoad:               return stLoadRead;
				opStore:              return stStore;
				opBpz, opBz, opBnz:   return stBranch;
				opStop:               return stStop;
				opNop:                return stNop;
				default:              return stReset;    // unknown byte
			endcase
		stAluExec, stShiftExec: return stWriteBack;
		stOriRead:  return stOriExec;
		stOriExec:  return stOriWrite;
		stLoadRead: return stLoadWrite;
		stStop:     return stStop;
		default:    return stFetch;    // last cycle of an instruction
	endcase
endfunction

// expected word, one field at a time from the per-state table
function automatic controlWord_t refControl(input ctrlState_t s, input opcode_t op,
		input logic nFlag, input logic zFlag);
	controlWord_t w;
	logic taken;
	taken = (op == opBpz && !nFlag) || (op == opBz && zFlag) || (op == opBnz && !zFlag);
	w.pcWrite     = (s == stFetch) || (s == stBranch && taken);
	w.addrSel     = (s == stFetch);
	w.memRead     = (s == stFetch) || (s == stLoadRead);
	w.memWrite    = (s == stStore);
	w.irLoad      = (s == stFetch);
	w.r1Sel       = (s == stOriRead) || (s == stOriWrite);
	w.mdrLoad     = (s == stLoadRead);
	w.r1r2Load    = (s == stDecode) || (s == stOriRead);
	w.alu1        = (s == stAluExec) || (s == stShiftExec) || (s == stOriExec);
	w.flagWrite   = w.alu1;    // every ALU cycle updates N and Z
	w.aluOutWrite = w.alu1 || (s == stLoadWrite);
	w.rfWrite     = (s == stWriteBack) || (s == stOriWrite) || (s == stLoadWrite);
	w.regIn       = (s == stLoadWrite);
	w.alu2 = (s == stFetch) ? src2One : (s == stShiftExec) ? src2Shift :
		(s == stOriExec) ? src2Imm : (s == stBranch) ? src2Branch : src2Reg;
	w.aluOp = (s == stShiftExec) ? aluShift : (s == stOriExec) ? aluOr :
		(s != stAluExec) ? aluAdd : (op == opSub) ? aluSub :
		(op == opNand) ? aluNand : aluAdd;
	return w;
endfunction

// File: dv/cpuControlTb.sv
// testbench for the cpuControl unit
// issues every instruction class and checks the control word each cycle
// against the reference model

`timescale 1ns/1ns

`include "cpuCtrl_defines.svh"

module cpuControlTb;

	import cpuCtrlPkg::*;

	`include "ctrlRefModel.svh"

	localparam int numInstr   = 46;
	localparam int cycleLimit = numInstr * 5 + 50;

	logic                    clock;
	logic                    reset;
	logic [`INSTR_WIDTH-1:0] instr;
	logic                    n;
	logic                    z;
	controlWord_t            control;

	ctrlState_t refState   = stReset;    // model copy of the sequencer state
	opcode_t    refOp      = opNop;      // class of the byte now in instr
	int         errors     = 0;
	int         checks     = 0;
	int         cycles     = 0;
	int         testErrors = 0;    // error count when the current test began

	cpuControl dut (.clock(clock), .reset(reset), .instr(instr), .n(n), .z(z),
		.control(control));

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// model state register, asynchronous reset like the sequencer
	always @(posedge clock or posedge reset)
	begin
		if (reset)
			refState <= stReset;
		else
			refState <= refNext(refState, refOp);
	end

	// compare 5 ns before the next edge, once state and inputs have settled
	always @(posedge clock)
	begin
		#35;
		compareValue("control", control, refControl(refState, refOp, n, z));
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic compareValue(input string name, input controlWord_t got,
			input controlWord_t expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("MISMATCH time %0t: %s is %h, expected %h",
				$time, name, got, expected);
		end
	endtask

	// three edges in reset, then step into the first fetch cycle
	task automatic applyReset();
		reset = 1'b1;
		repeat (3) @(posedge clock);
		#5;
		reset = 1'b0;
		@(posedge clock);
		#5;
	endtask

	// called during fetch, returns 5 ns into the next fetch cycle
	task automatic runInstr(input logic [`INSTR_WIDTH-1:0] code, input opcode_t op,
			input int len);
		@(posedge clock);
		#5;
		instr = code;
		refOp = op;
		n = lfsrBits(1) != 0;
		z = lfsrBits(1) != 0;
		repeat (len - 1) @(posedge clock);
		#5;
	endtask

	task automatic reportTest(input string name);
		$display("test %s: %0d mismatches", name, errors - testErrors);
		testErrors = errors;
	endtask

	initial
	begin
		reset = 1'b1;
		instr = `OPC_NOP;
		n = 1'b0;
		z = 1'b0;
		applyReset();
		runInstr(`OPC_NOP, opNop, 3);
		reportTest("reset");
		repeat (4)
		begin
			runInstr((lfsrBits(4) << 4) | `OPC_ADD, opAdd, 4);
			runInstr((lfsrBits(4) << 4) | `OPC_SUB, opSub, 4);
			runInstr((lfsrBits(4) << 4) | `OPC_NAND, opNand, 4);
			runInstr((lfsrBits(5) << 3) | `OPC_SHIFT, opShift, 4);
		end
		reportTest("alu");
		repeat (3)
		begin
			runInstr((lfsrBits(5) << 3) | `OPC_ORI, opOri, 5);
			runInstr((lfsrBits(4) << 4) | `OPC_LOAD, opLoad, 4);
			runInstr((lfsrBits(4) << 4) | `OPC_STORE, opStore, 3);
		end
		reportTest("ori, load, store");
		repeat (4)
		begin
			runInstr((lfsrBits(4) << 4) | `OPC_BPZ, opBpz, 3);
			runInstr((lfsrBits(4) << 4) | `OPC_BZ, opBz, 3);
			runInstr((lfsrBits(4) << 4) | `OPC_BNZ, opBnz, 3);
		end
		runInstr(`OPC_NOP, opNop, 3);
		reportTest("branch");
		runInstr((lfsrBits(4) << 4) | 8'h0A, opIllegal, 3);    // old vector codes
		runInstr((lfsrBits(4) << 4) | 8'h0C, opIllegal, 3);
		runInstr((lfsrBits(4) << 4) | 8'h0E, opIllegal, 3);
		runInstr(8'h11, opIllegal, 3);
		runInstr(8'hF1, opIllegal, 3);
		reportTest("unknown");
		runInstr(`OPC_STOP, opStop, 3);
		repeat (20)
		begin
			instr = lfsrBits(8);    // parked, inputs must not matter
			n = lfsrBits(1) != 0;
			z = lfsrBits(1) != 0;
			@(posedge clock);
			#5;
		end
		applyReset();
		runInstr((lfsrBits(4) << 4) | `OPC_ADD, opAdd, 4);
		reportTest("stop");
		@(posedge clock);
		#1;
		$display("checks: %0d, mismatches: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: src/cpuControl.sv
// cpuControl
// multi-cycle control unit of the 8-bit accumulator processor,
// decoder feeding the sequencer, both feeding the control table

`timescale 1ns/1ns

`include "cpuCtrl_defines.svh"

module cpuControl
(
	input  logic                     clock,
	input  logic                     reset,
	input  logic [`INSTR_WIDTH-1:0]  instr,
	input  logic                     n,
	input  logic                     z,
	output cpuCtrlPkg::controlWord_t control
);

	import cpuCtrlPkg::*;

	opcode_t    opcode;    // decoded instruction register
	ctrlState_t state;

	instrDecoder decoder
	(
		.instr  (instr),
		.opcode (opcode)
	);

	ctrlSequencer sequencer
	(
		.clock  (clock),
		.reset  (reset),
		.opcode (opcode),
		.state  (state)
	);

	controlTable table0
	(
		.state   (state),
		.opcode  (opcode),
		.n       (n),
		.z       (z),
		.control (control)
	);

endmodule

// File: src/controlTable.sv
// controlTable
// combinational control word for the datapath, built from the current
// state, with the branch decision and ALU op taken from opcode and flags

`timescale 1ns/1ns

module controlTable
(
	input  cpuCtrlPkg::ctrlState_t   state,
	input  cpuCtrlPkg::opcode_t      opcode,
	input  logic                     n,
	input  logic                     z,
	output cpuCtrlPkg::controlWord_t control
);

	import cpuCtrlPkg::*;

	logic branchTaken;

	// condition of the branch being executed
	always_comb
	begin
		case (opcode)
			opBpz:   branchTaken = ~n;
			opBz:    branchTaken = z;
			opBnz:   branchTaken = ~z;
			default: branchTaken = 1'b0;
		endcase
	end

	// ----------------------------------------------------------------------
	// per-state fields, everything not set stays zero
	// ----------------------------------------------------------------------
	always_comb
	begin
		control = '0;    // alu2 = src2Reg, aluOp = aluAdd
		case (state)
			stFetch:
			begin
				control.pcWrite = 1'b1;    // pc <- pc + 1
				control.addrSel = 1'b1;
				control.memRead = 1'b1;
				control.irLoad  = 1'b1;
				control.alu2    = src2One;
				control.aluOp   = aluAdd;
			end
			stDecode:
				control.r1r2Load = 1'b1;
			stAluExec:
			begin
				control.alu1        = 1'b1;
				control.aluOutWrite = 1'b1;
				control.flagWrite   = 1'b1;
				control.alu2        = src2Reg;
				case (opcode)
					opSub:   control.aluOp = aluSub;
					opNand:  control.aluOp = aluNand;
					default: control.aluOp = aluAdd;
				endcase
			end
			stShiftExec:
			begin
				control.alu1        = 1'b1;
				control.aluOutWrite = 1'b1;
				control.flagWrite   = 1'b1;
				control.alu2        = src2Shift;
				control.aluOp       = aluShift;
			end
			stWriteBack:
				control.rfWrite = 1'b1;
			stOriRead:
			begin
				control.r1Sel    = 1'b1;    // ori works on k1
				control.r1r2Load = 1'b1;
			end
			stOriExec:
			begin
				control.alu1        = 1'b1;
				control.aluOutWrite = 1'b1;
				control.flagWrite   = 1'b1;
				control.alu2        = src2Imm;
				control.aluOp       = aluOr;
			end
			stOriWrite:
			begin
				control.r1Sel   = 1'b1;
				control.rfWrite = 1'b1;
			end
			stLoadRead:
			begin
				control.memRead = 1'b1;
				control.mdrLoad = 1'b1;
			end
			stLoadWrite:
			begin
				control.aluOutWrite = 1'b1;
				control.rfWrite     = 1'b1;
				control.regIn       = 1'b1;    // write back from mdr
			end
			stStore:
				control.memWrite = 1'b1;
			stBranch:
			begin
				control.pcWrite = branchTaken;
				control.alu2    = src2Branch;
			end
			default:
				control = '0;    // reset, stop, nop
		endcase
	end

	// Checked at every state change, so the settled word of the state
	// being left is what gets sampled.
	memExclusive: assert property (
		@(state) !(control.memRead && control.memWrite)
	);

	pcWriteStates: assert property (
		@(state) control.pcWrite |-> (state == stFetch || state == stBranch)
	);

endmodule

// File: src/ctrlSequencer.sv
// ctrlSequencer
// state register and next-state logic of the fetch / decode / execute
// sequence, one state per clock cycle

`timescale 1ns/1ns

module ctrlSequencer
(
	input  logic                    clock,
	input  logic                    reset,
	input  cpuCtrlPkg::opcode_t     opcode,
	output cpuCtrlPkg::ctrlState_t  state
);

	import cpuCtrlPkg::*;

	ctrlState_t nextState;

	// ----------------------------------------------------------------------
	// next state
	// ----------------------------------------------------------------------
	always_comb
	begin
		case (state)
			stReset:     nextState = stFetch;
			stFetch:     nextState = stDecode;
			stDecode:
			begin
				case (opcode)
					opAdd, opSub, opNand:  nextState = stAluExec;
					opShift:               nextState = stShiftExec;
					opOri:                 nextState = stOriRead;
					opLoad:                nextState = stLoadRead;
					opStore:               nextState = stStore;
					opBpz, opBz, opBnz:    nextState = stBranch;
					opStop:                nextState = stStop;
					opNop:                 nextState = stNop;
					default:               nextState = stReset;    // unknown opcode
				endcase
			end
			stAluExec:   nextState = stWriteBack;
			stShiftExec: nextState = stWriteBack;
			stWriteBack: nextState = stFetch;
			stOriRead:   nextState = stOriExec;
			stOriExec:   nextState = stOriWrite;
			stOriWrite:  nextState = stFetch;
			stLoadRead:  nextState = stLoadWrite;
			stLoadWrite: nextState = stFetch;
			stStore:     nextState = stFetch;
			stBranch:    nextState = stFetch;
			stStop:      nextState = stStop;    // parked until reset
			stNop:       nextState = stFetch;
			default:     nextState = stReset;    // unused encoding
		endcase
	end

	// ----------------------------------------------------------------------
	// state register
	// ----------------------------------------------------------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= stReset;
		else
			state <= nextState;
	end

	// the sequence always moves on, only stop may park
	stateAdvances: assert property (
		@(posedge clock) disable iff (reset)
		(state != stStop) |=> (state != $past(state))
	);

endmodule

// File: src/instrDecoder.sv
// instrDecoder
// priority decode of the instruction byte into an opcode enum,
// unmatched bytes (including the old vector codes) give opIllegal

`timescale 1ns/1ns

`include "cpuCtrl_defines.svh"

module instrDecoder
(
	input  logic [`INSTR_WIDTH-1:0] instr,
	output cpuCtrlPkg::opcode_t     opcode
);

	import cpuCtrlPkg::*;

	// order matters, shift and ori only look at three bits
	always_comb
	begin
		if (instr[3:0] == `OPC_ADD)
			opcode = opAdd;
		else if (instr[3:0] == `OPC_SUB)
			opcode = opSub;
		else if (instr[3:0] == `OPC_NAND)
			opcode = opNand;
		else if (instr[2:0] == `OPC_SHIFT)
			opcode = opShift;
		else if (instr[2:0] == `OPC_ORI)
			opcode = opOri;
		else if (instr[3:0] == `OPC_LOAD)
			opcode = opLoad;
		else if (instr[3:0] == `OPC_STORE)
			opcode = opStore;
		else if (instr[3:0] == `OPC_BPZ)
			opcode = opBpz;
		else if (instr[3:0] == `OPC_BZ)
			opcode = opBz;
		else if (instr[3:0] == `OPC_BNZ)
			opcode = opBnz;
		else if (instr == `OPC_STOP)
			opcode = opStop;
		else if (instr == `OPC_NOP)
			opcode = opNop;
		else
			opcode = opIllegal;    // 1010, 1100, 1110 and stray x001 bytes
	end

endmodule

// File: common/cpuCtrlPkg.sv
// cpuCtrl package
// opcode, state and ALU enums plus the control word sent to the datapath

`include "cpuCtrl_defines.svh"

package cpuCtrlPkg;

	typedef enum logic [3:0] {
		opAdd, opSub, opNand, opShift, opOri,
		opLoad, opStore, opBpz, opBz, opBnz,
		opStop, opNop, opIllegal
	} opcode_t;

	typedef enum logic [3:0] {
		stReset, stFetch, stDecode,
		stAluExec, stShiftExec, stWriteBack,    // add/sub/nand and shift
		stOriRead, stOriExec, stOriWrite,
		stLoadRead, stLoadWrite,
		stStore, stBranch, stStop, stNop
	} ctrlState_t;

	typedef enum logic [`ALU_OP_WIDTH-1:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluOr    = 3'd2,
		aluNand  = 3'd3,
		aluShift = 3'd4
	} aluOp_t;

	typedef enum logic [`ALU_SRC2_WIDTH-1:0] {
		src2Reg    = 3'd0,
		src2One    = 3'd1,    // pc increment
		src2Branch = 3'd2,    // sign-extended branch offset
		src2Imm    = 3'd3,    // ori immediate
		src2Shift  = 3'd4     // shift amount and direction
	} aluSrc2_t;

	// 19-bit word, field order matches the datapath control bus
	typedef struct packed {
		logic     pcWrite;
		logic     addrSel;
		logic     memRead;
		logic     memWrite;
		logic     irLoad;
		logic     r1Sel;
		logic     mdrLoad;
		logic     r1r2Load;
		logic     alu1;
		aluSrc2_t alu2;
		aluOp_t   aluOp;
		logic     aluOutWrite;
		logic     rfWrite;
		logic     regIn;
		logic     flagWrite;
	} controlWord_t;

endpackage

// File: common/cpuCtrl_defines.svh
// cpuCtrl defines
// instruction width, ALU field widths and the opcode encodings
// of the scalar instruction set

`ifndef CPU_CTRL_DEFINES_SVH
`define CPU_CTRL_DEFINES_SVH

`define INSTR_WIDTH     8

`define ALU_OP_WIDTH    3
`define ALU_SRC2_WIDTH  3

// ----------------------------------------------------------------------
// opcodes matched on the low nibble
`define OPC_ADD         4'b0100
`define OPC_SUB         4'b0110
`define OPC_NAND        4'b1000
`define OPC_LOAD        4'b0000
`define OPC_STORE       4'b0010
`define OPC_BPZ         4'b1101
`define OPC_BZ          4'b0101
`define OPC_BNZ         4'b1001

// opcodes matched on the low three bits, the rest carries the operand
`define OPC_SHIFT       3'b011
`define OPC_ORI         3'b111

// opcodes matched on the whole byte
`define OPC_STOP        8'b00000001
`define OPC_NOP         8'b10000001

`endif
